//--- mux_local.f
+incdir+rtl
rtl/eject_pkg.sv
rtl/port_fifo.sv
rtl/eject_decode.sv
rtl/reduce_execute.sv
rtl/mux_local.sv
sim/tb_mux_local.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the ejection stage testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
{ verilator --binary --timing --assert --top-module tb_mux_local \
    -f mux_local.f -o sim_mux_local \
    && ./obj_dir/sim_mux_local; } > "$log" 2>&1 \
    || echo "Test failed" >> "$log"
grep -q "Test failed" "$log" \
    && { echo "simulation FAILED, see $log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- sim/tb_mux_local.sv
// testbench for mux_local: plain and reduction traffic with scoreboards, run through run_sim.sh
`include "eject_config.svh"

module tb_mux_local;

    import eject_pkg::*;

    // cycle budget per test, the watchdog is built from their sum
    localparam int RESET_CYCLES   = 10;
    localparam int PASS_CYCLES    = 120;
    localparam int STALL_CYCLES   = 20;
    localparam int SINGLE_CYCLES  = 300;
    localparam int CONTEND_CYCLES = 150;
    localparam int REUSE_CYCLES   = 60;
    localparam int STIM_CYCLES    = RESET_CYCLES + PASS_CYCLES + STALL_CYCLES
                                  + SINGLE_CYCLES + CONTEND_CYCLES + REUSE_CYCLES;
    localparam int DRAIN_LIMIT    = 200;

    logic       clk;
    logic       rst;
    flit_vec_t  in_flits;
    port_mask_t in_stall;
    port_mask_t in_avail;
    flit_vec_t  out_flits;
    flit_t      out_reduction;

    flit_t       exp_port [`EJ_NUM_PORTS][$];  // plain flits per port, in send order
    flit_t       pending [`EJ_NUM_PORTS][$];   // stimulus waiting for room
    flit_t       exp_red [int];                // combined flit by table index
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors;

    mux_local mux_local_inst (
        .clk           (clk),
        .rst           (rst),
        .in_flits      (in_flits),
        .in_stall      (in_stall),
        .in_avail      (in_avail),
        .out_flits     (out_flits),
        .out_reduction (out_reduction)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected combined flit of one group, members in arrival order
    function automatic flit_t group_result(input flit_t members[$]);
        flit_t r;
        r = '0;
        r.valid  = 1'b1;
        r.reduce = 1'b1;
        foreach (members[k]) begin
            r.weight  = r.weight + members[k].weight;    // sums wrap at field width
            r.payload = r.payload + members[k].payload;
            r.fanin   = members[k].fanin;
            r.index   = members[k].index;
            r.tag     = members[k].tag;                  // last arrival wins
        end
        return r;
    endfunction

    function automatic flit_t plain_flit();
        flit_t f;
        f = {rand32(), rand32()};
        f.valid  = 1'b1;
        f.reduce = 1'b0;
        return f;
    endfunction

    function automatic flit_t red_member(input int fanin, input int idx, input tag_t tag);
        flit_t f;
        f = {rand32(), rand32()};
        f.valid  = 1'b1;
        f.reduce = 1'b1;
        f.fanin  = fanin_t'(fanin);
        f.index  = table_idx_t'(idx);
        f.tag    = tag;
        return f;
    endfunction

    function automatic int outstanding();
        int total;
        total = exp_red.num();
        for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
            total += exp_port[p].size();
        end
        return total;
    endfunction

    // one flit per port per cycle, only where in_avail says there is room
    task automatic feed_pending();
        int left;
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            #2;
            left     = 0;
            in_flits = '0;
            for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
                if (pending[p].size() > 0 && in_avail[p]) begin
                    in_flits[p] = pending[p].pop_front();
                    if (!in_flits[p].reduce) exp_port[p].push_back(in_flits[p]);
                end
                left += pending[p].size();
            end
            guard++;
        end while (left > 0 && guard < DRAIN_LIMIT);
        @(posedge clk);
        #2;
        in_flits = '0;
        if (left > 0) begin
            $display("stimulus stuck, %0d flits could not be sent", left);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (outstanding() > 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (outstanding() > 0) begin
            $display("%0d expected outputs never arrived", outstanding());
            errors++;
        end
        repeat (4) @(negedge clk);  // room for stray extra outputs
    endtask

    // members go out one at a time so their arrival order is known
    task automatic run_group(input int fanin, input int idx, input int first_port);
        flit_t members[$];
        int    cnt;
        cnt = (fanin == 0) ? 1 : fanin;  // fanin 0 completes on one flit
        for (int j = 0; j < cnt; j++) begin
            members.push_back(red_member(fanin, idx, tag_t'(rand32())));
        end
        exp_red[idx] = group_result(members);
        foreach (members[j]) begin
            pending[(first_port + j) % `EJ_NUM_PORTS].push_back(members[j]);
            feed_pending();
        end
        wait_drain();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %0s: FAIL with %0d errors", name, errors - test_errors);
        end else begin
            $display("test %0s: ok", name);
        end
        test_errors = errors;
    endtask

    // scoreboard, outputs are stable at the falling edge
    always @(negedge clk) begin
        flit_t want;
        int    ridx;
        if (!rst) begin
            for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
                if (out_flits[p].valid) begin
                    assert (exp_port[p].size() > 0) else begin
                        $display("port %0d sent flit %h that nobody expected", p, out_flits[p]);
                        errors++;
                    end
                    if (exp_port[p].size() > 0) begin
                        want = exp_port[p].pop_front();
                        checks++;
                        assert (out_flits[p] == want) else begin
                            $display("Mismatch out_flits[%0d]: got %h expected %h",
                                     p, out_flits[p], want);
                            errors++;
                        end
                    end
                end
            end
            if (out_reduction.valid) begin
                ridx = int'(out_reduction.index);
                assert (exp_red.exists(ridx)) else begin
                    $display("reduction result for index %0d with no group open", ridx);
                    errors++;
                end
                if (exp_red.exists(ridx)) begin
                    checks++;
                    assert (out_reduction == exp_red[ridx]) else begin
                        $display("Mismatch out_reduction: got %h expected %h",
                                 out_reduction, exp_red[ridx]);
                        errors++;
                    end
                    exp_red.delete(ridx);
                end
            end
        end
    end

    initial begin
        #(40 * (STIM_CYCLES + 200));
        $display("watchdog expired after %0d cycles", STIM_CYCLES + 200);
        $display("Test failed");
        $finish;
    end

    initial begin
        flit_t      members[$];
        flit_t      f;
        port_mask_t mask;
        int         n;
        tag_t       tag;
        rng_state    = 32'd64413;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        in_flits     = '0;
        in_stall     = '0;
        rst          = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (4) @(posedge clk);
        #2;
        checks++;
        assert (in_avail == '1) else begin
            $display("Mismatch in_avail: got %h expected %h", in_avail, {`EJ_NUM_PORTS{1'b1}});
            errors++;
        end
        finish_test("reset");

        for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
            n = 20 + int'(rand32() % 32'd10);
            repeat (n) pending[p].push_back(plain_flit());
        end
        feed_pending();
        wait_drain();
        // latency on an idle port, second edge after driving
        f = plain_flit();
        @(posedge clk);
        #2;
        in_flits[3] = f;
        exp_port[3].push_back(f);
        @(posedge clk);
        #1;
        assert (!out_flits[3].valid) else begin
            $display("port 3 flit left one edge early");
            errors++;
        end
        #1;
        in_flits = '0;
        @(posedge clk);
        #1;
        checks++;
        assert (out_flits[3] == f) else begin
            $display("Mismatch out_flits[3]: got %h expected %h", out_flits[3], f);
            errors++;
        end
        wait_drain();
        finish_test("pass_through");

        @(posedge clk);
        #2;
        mask = port_mask_t'(rand32());
        for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
            in_flits[p] = plain_flit();
            if (!mask[p]) exp_port[p].push_back(in_flits[p]);
        end
        in_stall = mask;
        @(posedge clk);
        #2;
        in_stall = '1;  // every port stalled, nothing may get through
        for (int p = 0; p < `EJ_NUM_PORTS; p++) in_flits[p] = plain_flit();
        @(posedge clk);
        #2;
        in_flits = '0;
        in_stall = '0;
        wait_drain();
        finish_test("stall");

        for (int k = 0; k <= 7; k++) run_group(k, k + 4, k);
        finish_test("single_reduction");

        // groups on indices 12 to 15 land on all ports at once
        for (int g = 0; g < 4; g++) begin
            n   = 1 + int'(rand32() % 32'd7);
            tag = tag_t'(rand32());
            members.delete();
            for (int j = 0; j < n; j++) begin
                f = red_member(n, 12 + g, tag);
                members.push_back(f);
                pending[(2 * g + j) % `EJ_NUM_PORTS].push_back(f);
            end
            exp_red[12 + g] = group_result(members);
            for (int p = 0; p < `EJ_NUM_PORTS; p++) pending[p].push_back(plain_flit());
        end
        feed_pending();
        wait_drain();
        finish_test("contention");

        run_group(3, 5, 2);
        run_group(5, 5, 4);
        finish_test("reuse");

        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/mux_local.sv
// local-port ejection stage of the torus switch, wires the port FIFOs, decode and reduction table
`include "eject_config.svh"

module mux_local (
    input  logic                  clk,
    input  logic                  rst,
    input  eject_pkg::flit_vec_t  in_flits,
    input  eject_pkg::port_mask_t in_stall,
    output eject_pkg::port_mask_t in_avail,
    output eject_pkg::flit_vec_t  out_flits,
    output eject_pkg::flit_t      out_reduction
);

    import eject_pkg::*;

    flit_vec_t  heads;
    port_mask_t fifo_full;
    port_mask_t fifo_empty;
    port_mask_t consume;
    flit_t      red_flit;

    assign in_avail = ~fifo_full;

    for (genvar p = 0; p < `EJ_NUM_PORTS; p++) begin : gen_port
        port_fifo #(
            .DEPTH (`EJ_FIFO_DEPTH),
            .WIDTH ($bits(flit_t))
        ) fifo_port (
            .clk     (clk),
            .rst     (rst),
            .wr_data (in_flits[p]),
            .wr_en   (in_flits[p].valid && !in_stall[p]),  // stalled flits are dropped here
            .rd_en   (consume[p]),
            .rd_data (heads[p]),
            .full    (fifo_full[p]),
            .empty   (fifo_empty[p])
        );
    end

    eject_decode eject_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .heads     (heads),
        .empty     (fifo_empty),
        .consume   (consume),
        .out_flits (out_flits),
        .red_flit  (red_flit)
    );

    reduce_execute reduce_execute_inst (
        .clk           (clk),
        .rst           (rst),
        .red_flit      (red_flit),
        .out_reduction (out_reduction)
    );

endmodule

//--- rtl/reduce_execute.sv
// reduction table: reads an entry, accumulates one flit, writes back and emits the combined packet
`include "eject_config.svh"

module reduce_execute (
    input  logic             clk,
    input  logic             rst,
    input  eject_pkg::flit_t red_flit,
    output eject_pkg::flit_t out_reduction
);

    import eject_pkg::*;

    table_entry_t tbl [`EJ_TABLE_DEPTH];

    // read stage, entry registered beside its flit
    flit_t        rd_flit;
    table_entry_t rd_entry;

    // accumulate stage
    fanin_t       need;
    table_entry_t next_entry;
    flit_t        combined;
    logic         done;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_flit <= '0;
        end else begin
            rd_flit <= red_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (red_flit.valid) begin
            rd_entry <= tbl[red_flit.index];
        end
    end

    always_comb begin
        need = (rd_flit.fanin == '0) ? fanin_t'(1) : rd_flit.fanin;  // fanin 0 acts as 1

        // sums wrap at their widths
        next_entry.count       = rd_entry.count + fanin_t'(1);
        next_entry.weight_sum  = rd_entry.weight_sum + rd_flit.weight;
        next_entry.payload_sum = rd_entry.payload_sum + rd_flit.payload;

        done = rd_flit.valid && (next_entry.count == need);
    end

    // result carries the group's index and fanin, and the last tag
    always_comb begin
        combined.valid   = 1'b1;
        combined.reduce  = 1'b1;
        combined.fanin   = rd_flit.fanin;
        combined.index   = rd_flit.index;
        combined.weight  = next_entry.weight_sum;
        combined.payload = next_entry.payload_sum;
        combined.tag     = rd_flit.tag;
    end

    // write-back, a finished group leaves a zero entry for the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EJ_TABLE_DEPTH; i++) begin
                tbl[i] <= '0;
            end
        end else if (rd_flit.valid) begin
            tbl[rd_flit.index] <= done ? '0 : next_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_reduction <= '0;
        end else begin
            out_reduction <= done ? combined : '0;
        end
    end

    // a stored count below fanin means groups never overrun their entry
    a_count_below_fanin: assert property (@(posedge clk) disable iff (rst)
        rd_flit.valid |-> (rd_entry.count < need))
        else $error("reduce_execute: entry %0d count %0d reached fanin %0d",
                    rd_flit.index, rd_entry.count, need);

endmodule

//--- rtl/eject_decode.sv
// sorts FIFO heads into pass-through and reduction traffic and arbitrates one reduction per grant
`include "eject_config.svh"

module eject_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  eject_pkg::flit_vec_t  heads,
    input  eject_pkg::port_mask_t empty,
    output eject_pkg::port_mask_t consume,
    output eject_pkg::flit_vec_t  out_flits,
    output eject_pkg::flit_t      red_flit
);

    import eject_pkg::*;

    localparam port_idx_t NO_GRANT = 3'd7;

    grant_state_t state;
    grant_state_t state_next;
    port_mask_t   plain_head;  // ordinary packet at the head
    port_mask_t   red_head;    // reduction packet at the head
    port_mask_t   red_consume;
    port_idx_t    grant;

    // empty FIFOs have no head to classify
    always_comb begin
        for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
            plain_head[p] = !empty[p] && !heads[p].reduce;
            red_head[p]   = !empty[p] && heads[p].reduce;
        end
    end

    // lowest port with a reduction head wins while the arbiter is open
    always_comb begin
        grant = NO_GRANT;
        if (state == GRANT_OPEN) begin
            for (int p = `EJ_NUM_PORTS - 1; p >= 0; p--) begin
                if (red_head[p]) begin
                    grant = port_idx_t'(p);
                end
            end
        end
    end

    // plain heads always drain and a reduction head drains only on its grant
    always_comb begin
        for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
            red_consume[p] = red_head[p] && (grant == port_idx_t'(p));
            consume[p]     = plain_head[p] || red_consume[p];
        end
    end

    always_comb begin
        case (state)
            GRANT_OPEN: state_next = (|red_head) ? GRANT_HOLD : GRANT_OPEN;
            GRANT_HOLD: state_next = GRANT_OPEN;  // gives the table time to write back
            default:    state_next = GRANT_OPEN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GRANT_OPEN;
        end else begin
            state <= state_next;
        end
    end

    // each port's plain head goes straight to its own output
    always_ff @(posedge clk) begin
        if (rst) begin
            out_flits <= '0;
        end else begin
            for (int p = 0; p < `EJ_NUM_PORTS; p++) begin
                out_flits[p] <= plain_head[p] ? heads[p] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            red_flit <= '0;
        end else if (grant != NO_GRANT) begin
            red_flit <= heads[grant];
        end else begin
            red_flit <= '0;  // no reduction entering
        end
    end

    // the cycle after a grant stays idle so the table writes back first
    a_idle_after_grant: assert property (@(posedge clk) disable iff (rst)
        (|red_consume) |=> !(|red_consume))
        else $error("eject_decode: reduction consumed in the hold cycle");

endmodule

//--- rtl/port_fifo.sv
// per-port input FIFO, circular buffer with full and empty status, one per ejection port
module port_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             do_wr;
    logic             do_rd;

    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || rd_en); // a full FIFO takes a write only beside a read

    assign full    = (fill == CNT_W'(DEPTH));
    assign empty   = (fill == '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;   // both or neither
            endcase
        end
    end

    // the upstream watches in_avail and must not push into a full FIFO
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full)
        else $error("port_fifo: write while full, flit lost");

    // decode only consumes heads it saw as present
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty)
        else $error("port_fifo: read while empty");

endmodule

//--- rtl/eject_pkg.sv
// shared types of the ejection stage: flit layout, reduction table entry and field widths
`include "eject_config.svh"

package eject_pkg;

    typedef logic [2:0]  port_idx_t;   // 7 = no grant
    typedef logic [3:0]  table_idx_t;
    typedef logic [2:0]  fanin_t;      // packets expected per reduction
    typedef logic [7:0]  weight_t;
    typedef logic [31:0] payload_t;
    typedef logic [14:0] tag_t;        // opaque, carried through

    // 64-bit flit, valid bit on top
    typedef struct packed {
        logic       valid;
        logic       reduce;            // set for reduction packets
        fanin_t     fanin;
        table_idx_t index;
        weight_t    weight;
        payload_t   payload;
        tag_t       tag;
    } flit_t;

    // one flit per port, port 0 in the low bits
    typedef flit_t [`EJ_NUM_PORTS-1:0] flit_vec_t;

    typedef logic [`EJ_NUM_PORTS-1:0] port_mask_t;

    // running state of one reduction group, 43 bits
    typedef struct packed {
        fanin_t   count;               // arrivals so far
        weight_t  weight_sum;
        payload_t payload_sum;
    } table_entry_t;

    // reduction arbiter, one idle cycle after every grant
    typedef enum logic {
        GRANT_OPEN,
        GRANT_HOLD
    } grant_state_t;

endpackage

//--- rtl/eject_config.svh
// sizing constants for the ejection stage, included by the package and by the RTL modules
`ifndef EJECT_CONFIG_SVH
`define EJECT_CONFIG_SVH

// ports in order: local, yneg, ypos, xpos, xneg, zpos, zneg
`define EJ_NUM_PORTS 7

// entries in each per-port input FIFO
`define EJ_FIFO_DEPTH 4

// reduction table entries, one per table index
// must match the width of table_idx_t
`define EJ_TABLE_DEPTH 16

`endif
